// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := issue_ctrl_tb
FILELIST := all.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/params_pkg.sv
common/pipe_pkg.sv
hazard/hazard_unit.sv
verilog/mul_tracker.sv
verilog/mem_unit_fsm.sv
verilog/rob_counter.sv
verilog/wb_arbiter.sv
verilog/issue_ctrl_top.sv
verification/issue_ctrl_chk.sv
verification/issue_ctrl_tb.sv

// ==== common/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Architectural register index width
`define REGISTER_WIDTH 5

// Multiplier pipeline depth, ex1 to ex5
`define MUL_STAGES 5

`define ROB_DEPTH 8

// Busy cycles for one load or store
`define MEM_LATENCY 3

`endif

// ==== common/params_pkg.sv ====
`include "core_defs.svh"

package params_pkg;

  // Instruction class as seen by decode
  typedef enum logic [2:0] {
    kind_alu    = 3'd0,
    kind_mul    = 3'd1,
    kind_load   = 3'd2,
    kind_store  = 3'd3,
    kind_branch = 3'd4,
    kind_jump   = 3'd5
  } instr_kind_e;

  typedef struct packed {
    logic [`REGISTER_WIDTH-1:0] rs1;
    logic [`REGISTER_WIDTH-1:0] rs2;
    logic                       rs1_needed;
    logic                       rs2_needed;
    logic                       is_mul;
  } hazard_ctrl_t;

  typedef struct packed {
    logic                       valid;
    instr_kind_e                kind;
    logic [`REGISTER_WIDTH-1:0] rd;
    logic                       rd_wr_en;
    hazard_ctrl_t               hazard;
  } dec_instr_t;

endpackage : params_pkg

// ==== common/pipe_pkg.sv ====
`include "core_defs.svh"

package pipe_pkg;

  typedef struct packed {
    logic                       valid;
    logic                       instr_finishes;
    logic                       branch_taken;
    logic                       is_jump;
    logic [`REGISTER_WIDTH-1:0] wr_reg;
  } alu_status_t;

  typedef enum logic [1:0] {
    mem_idle = 2'd0,
    mem_busy = 2'd1,
    mem_done = 2'd2
  } mem_state_e;

  typedef struct packed {
    logic                       valid;
    logic                       busy;
    logic                       reg_wr_en;
    logic [`REGISTER_WIDTH-1:0] wr_reg;
  } mem_status_t;

  // One multiplier stage
  typedef struct packed {
    logic                       valid;
    logic [`REGISTER_WIDTH-1:0] wr_reg;
  } ex_slot_t;

  typedef enum logic [1:0] {
    wb_none = 2'd0,
    wb_mem  = 2'd1,
    wb_mul  = 2'd2,
    wb_alu  = 2'd3
  } wb_src_e;

  typedef struct packed {
    logic                       valid;
    wb_src_e                    src;
    logic [`REGISTER_WIDTH-1:0] wr_reg;
  } wb_t;

  typedef struct packed {
    logic flush;
    logic stall_fetch;
    logic stall_decode;
    logic stall_alu;
    logic stall_ex;
    logic stall_mem;
    logic alu_bubble;
    logic ex_bubble;
  } stall_vec_t;

endpackage : pipe_pkg

// ==== hazard/hazard_unit.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module hazard_unit
  import params_pkg::*;
  import pipe_pkg::*;
(
  input  logic                           rob_is_full_i,
  input  logic                           dec_valid_i,
  input  var hazard_ctrl_t               hazard_signals_i,
  input  var alu_status_t                alu_status_i,
  input  var mem_status_t                mem_status_i,
  input  var ex_slot_t [`MUL_STAGES-1:0] ex_slots_i,
  input  logic                           ex_allowed_wb_i,
  input  logic                           alu_allowed_wb_i,
  output stall_vec_t                     stall_o
);

  logic rs1_live;
  logic rs2_live;
  logic ex_full;
  logic ex_raw;
  logic mem_writing;
  logic mem_raw;
  logic stall_ex;
  logic stall_alu;
  logic ex_backpressure;
  logic alu_backpressure;
  logic stall_decode;

  // x0 never creates a dependency
  assign rs1_live = dec_valid_i && hazard_signals_i.rs1_needed && (hazard_signals_i.rs1 != '0);
  assign rs2_live = dec_valid_i && hazard_signals_i.rs2_needed && (hazard_signals_i.rs2 != '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RAW detection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ex5 is left out of the match, its result is on the write-back port
  always_comb begin : ex_scan
    ex_full = 1'b1;
    ex_raw  = 1'b0;
    for (int i = 0; i < `MUL_STAGES; i++) begin
      ex_full = ex_full && ex_slots_i[i].valid;
      if ((i < `MUL_STAGES - 1) && ex_slots_i[i].valid) begin
        if ((rs1_live && (ex_slots_i[i].wr_reg == hazard_signals_i.rs1)) ||
            (rs2_live && (ex_slots_i[i].wr_reg == hazard_signals_i.rs2))) begin
          ex_raw = 1'b1;
        end
      end
    end
  end

  assign mem_writing = mem_status_i.valid && mem_status_i.busy && mem_status_i.reg_wr_en;

  assign mem_raw = mem_writing &&
                   ((rs1_live && (mem_status_i.wr_reg == hazard_signals_i.rs1)) ||
                    (rs2_live && (mem_status_i.wr_reg == hazard_signals_i.rs2)));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Back-pressure
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign stall_ex = ex_full && !ex_allowed_wb_i;

  // Lost the port, or waiting behind a busy memory access
  assign stall_alu = alu_status_i.valid &&
                     ((alu_status_i.instr_finishes && !alu_allowed_wb_i) ||
                      (!alu_status_i.instr_finishes && mem_status_i.busy));

  assign ex_backpressure  = hazard_signals_i.is_mul && stall_ex;
  assign alu_backpressure = !hazard_signals_i.is_mul && stall_alu;

  assign stall_decode = rob_is_full_i    ||
                        ex_backpressure  ||
                        alu_backpressure ||
                        ex_raw           ||
                        mem_raw;

  always_comb begin : pack_out
    stall_o.flush        = alu_status_i.branch_taken || alu_status_i.is_jump;
    stall_o.stall_fetch  = stall_decode;
    stall_o.stall_decode = stall_decode;
    stall_o.stall_alu    = stall_alu;
    stall_o.stall_ex     = stall_ex;
    stall_o.stall_mem    = mem_status_i.busy;
    // A stalled unit keeps its own contents, no bubble
    stall_o.alu_bubble   = stall_decode && !alu_backpressure;
    stall_o.ex_bubble    = stall_decode && !ex_backpressure;
  end

endmodule : hazard_unit

// ==== verification/issue_ctrl_chk.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module issue_ctrl_chk
  import pipe_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  var stall_vec_t                 stall_i,
  input  var wb_t                        wb_i,
  input  var ex_slot_t [`MUL_STAGES-1:0] ex_slots_i,
  input  var mem_status_t                mem_status_i,
  input  var alu_status_t                alu_status_i,
  input  logic                           ex_allowed_wb_i,
  input  logic                           alu_allowed_wb_i
);

  int   fail_cnt = 0;
  logic mem_grant;
  logic alu_grant;

  assign mem_grant = mem_status_i.valid && !mem_status_i.busy && mem_status_i.reg_wr_en;
  assign alu_grant = alu_allowed_wb_i && alu_status_i.valid && alu_status_i.instr_finishes;

  fetch_follows_decode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_i.stall_fetch == stall_i.stall_decode)
  else begin
    fail_cnt++;
    $error("stall_fetch and stall_decode differ");
  end

  // Single write-back port
  one_wb_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({mem_grant, ex_allowed_wb_i, alu_grant}))
  else begin
    fail_cnt++;
    $error("More than one write-back source granted");
  end

  mul_wb_needs_ex5: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (wb_i.valid && (wb_i.src == wb_mul)) |-> ex_slots_i[`MUL_STAGES-1].valid)
  else begin
    fail_cnt++;
    $error("Multiplier write-back without a valid ex5 slot");
  end

endmodule : issue_ctrl_chk

bind issue_ctrl_top issue_ctrl_chk u_chk (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .stall_i          (stall_o),
  .wb_i             (wb_o),
  .ex_slots_i       (ex_slots),
  .mem_status_i     (mem_status),
  .alu_status_i     (alu_status_i),
  .ex_allowed_wb_i  (ex_allowed_wb),
  .alu_allowed_wb_i (alu_allowed_wb)
);

// ==== verification/issue_ctrl_golden.txt ====
# test  dec_instr  alu_status  retire  stall_o  wb_o   (test and retire decimal, others hex)
# One line per clock cycle. Expected outputs hold just before the next rising edge
1 482117 000 1 00 00
1 426006 000 1 00 00
1 49E117 000 1 00 00
1 422706 000 0 63 00
1 422706 000 0 63 00
1 422706 000 0 63 C0
1 422706 000 0 63 00
1 422706 000 1 00 C7
2 516104 000 1 00 00
2 42A504 000 0 67 00
2 42A504 000 0 67 00
2 42A504 000 0 67 00
2 42A504 000 1 00 A5
3 51A104 000 1 00 00
3 000000 000 0 04 00
3 000000 000 0 04 00
3 000000 000 0 04 00
3 42E104 18C 0 71 A6
3 42E104 18C 1 00 EC
4 4C2117 000 1 00 00
4 4C6117 000 1 00 00
4 4CA117 000 1 00 00
4 4CE117 000 1 00 00
4 4D2117 000 1 00 00
4 50E104 000 1 00 D0
4 000000 000 0 04 D1
4 000000 000 0 04 D2
4 000000 000 0 04 D3
4 000000 000 0 00 A3
4 000000 000 0 00 D4
5 432104 000 0 00 00
5 432104 000 0 00 00
5 432104 000 0 00 00
5 432104 000 0 00 00
5 432104 000 0 00 00
5 432104 000 0 00 00
5 432104 000 0 00 00
5 432104 000 0 00 00
5 432104 000 1 63 00
5 432104 000 1 00 00
6 600116 000 1 00 00
6 000000 140 0 80 00
6 000000 1A1 0 80 E1
6 000000 000 0 00 00

// ==== verification/issue_ctrl_tb.sv ====
`timescale 1ns/1ns

module issue_ctrl_tb
  import params_pkg::*;
  import pipe_pkg::*;
();

  localparam string GOLDEN_FILE = "verification/issue_ctrl_golden.txt";
  localparam int    CLK_PERIOD  = 4;

  logic        clk = 1'b0;
  logic        arst_n;
  dec_instr_t  dec_instr;
  alu_status_t alu_status;
  logic        retire;
  stall_vec_t  stall;
  wb_t         wb;

  // One entry per golden line
  int          test_q[$];
  dec_instr_t  dec_q[$];
  alu_status_t alu_q[$];
  logic        retire_q[$];
  stall_vec_t  stall_exp_q[$];
  wb_t         wb_exp_q[$];

  int n_lines      = 0;
  int test_errs    = 0;
  int total_errs   = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  issue_ctrl_top u_dut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .dec_instr_i  (dec_instr),
    .alu_status_i (alu_status),
    .retire_i     (retire),
    .stall_o      (stall),
    .wb_o         (wb)
  );

  task automatic read_golden();
    int          fd;
    int          t;
    int          r;
    logic [22:0] d;
    logic [8:0]  a;
    logic [7:0]  s;
    logic [7:0]  w;
    string       line;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open %s", GOLDEN_FILE);
    end else begin
      while ($fgets(line, fd) > 0) begin
        // Comment and blank lines carry no vector
        if ((line.len() > 1) && (line.getc(0) != "#") &&
            ($sscanf(line, "%d %h %h %d %h %h", t, d, a, r, s, w) == 6)) begin
          test_q.push_back(t);
          dec_q.push_back(dec_instr_t'(d));
          alu_q.push_back(alu_status_t'(a));
          retire_q.push_back(r[0]);
          stall_exp_q.push_back(stall_vec_t'(s));
          wb_exp_q.push_back(wb_t'(w));
        end
      end
      $fclose(fd);
    end
    n_lines = test_q.size();
  endtask

  task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("Fail %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_outputs(input stall_vec_t s_exp, input wb_t w_exp);
    check_field("stall.flush",        stall.flush,        s_exp.flush);
    check_field("stall.stall_fetch",  stall.stall_fetch,  s_exp.stall_fetch);
    check_field("stall.stall_decode", stall.stall_decode, s_exp.stall_decode);
    check_field("stall.stall_alu",    stall.stall_alu,    s_exp.stall_alu);
    check_field("stall.stall_ex",     stall.stall_ex,     s_exp.stall_ex);
    check_field("stall.stall_mem",    stall.stall_mem,    s_exp.stall_mem);
    check_field("stall.alu_bubble",   stall.alu_bubble,   s_exp.alu_bubble);
    check_field("stall.ex_bubble",    stall.ex_bubble,    s_exp.ex_bubble);
    check_field("wb.valid",           wb.valid,           w_exp.valid);
    check_field("wb.src",             wb.src,             w_exp.src);
    check_field("wb.wr_reg",          wb.wr_reg,          w_exp.wr_reg);
  endtask

  task automatic finish_test(input int num, input int cycles);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("Test %0d finished after %0d cycles with %0d mismatches", num, cycles, test_errs);
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : run
    int cur_test;
    int test_cycles;
    arst_n     = 1'b0;
    dec_instr  = '0;
    alu_status = '0;
    retire     = 1'b0;
    read_golden();
    if (n_lines == 0) begin
      $display("Golden file gave no vectors, nothing was run");
      total_errs++;
    end
    repeat (3) @(posedge clk);
    #1;
    arst_n      = 1'b1;
    cur_test    = (n_lines > 0) ? test_q[0] : 0;
    test_cycles = 0;
    for (int i = 0; i < n_lines; i++) begin
      if (test_q[i] != cur_test) begin
        finish_test(cur_test, test_cycles);
        cur_test    = test_q[i];
        test_cycles = 0;
      end
      dec_instr  = dec_q[i];
      alu_status = alu_q[i];
      retire     = retire_q[i];
      // Sample just before the next rising edge
      #(CLK_PERIOD - 2);
      check_outputs(stall_exp_q[i], wb_exp_q[i]);
      test_cycles++;
      @(posedge clk);
      #1;
    end
    if (n_lines > 0) begin
      finish_test(cur_test, test_cycles);
    end
    total_errs += u_dut.u_chk.fail_cnt;
    $display("%0d tests run, %0d with mismatches, %0d errors in total",
             tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (n_lines > 0);
    #(n_lines * CLK_PERIOD * 2);
    $display("Watchdog expired, the golden file did not finish");
    $display("TEST FAILED");
    $finish;
  end

endmodule : issue_ctrl_tb

// ==== verilog/issue_ctrl_top.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module issue_ctrl_top
  import params_pkg::*;
  import pipe_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  var dec_instr_t  dec_instr_i,
  input  var alu_status_t alu_status_i,
  input  logic            retire_i,
  output stall_vec_t      stall_o,
  output wb_t             wb_o
);

  ex_slot_t [`MUL_STAGES-1:0] ex_slots;
  mem_status_t                mem_status;
  logic                       rob_full;
  logic                       ex_allowed_wb;
  logic                       alu_allowed_wb;
  logic                       issue;

  // Single issue condition shared by all tracking blocks
  assign issue = dec_instr_i.valid && !stall_o.stall_decode;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Unit trackers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mul_tracker u_mul_tracker (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .issue_i         (issue),
    .dec_instr_i     (dec_instr_i),
    .ex_allowed_wb_i (ex_allowed_wb),
    .ex_slots_o      (ex_slots)
  );

  mem_unit_fsm u_mem_unit_fsm (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .issue_i      (issue),
    .dec_instr_i  (dec_instr_i),
    .mem_status_o (mem_status)
  );

  rob_counter u_rob_counter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .issue_i    (issue),
    .retire_i   (retire_i),
    .rob_full_o (rob_full)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbitration and hazards
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  wb_arbiter u_wb_arbiter (
    .mem_status_i     (mem_status),
    .ex5_slot_i       (ex_slots[`MUL_STAGES-1]),
    .alu_status_i     (alu_status_i),
    .ex_allowed_wb_o  (ex_allowed_wb),
    .alu_allowed_wb_o (alu_allowed_wb),
    .wb_o             (wb_o)
  );

  hazard_unit u_hazard_unit (
    .rob_is_full_i    (rob_full),
    .dec_valid_i      (dec_instr_i.valid),
    .hazard_signals_i (dec_instr_i.hazard),
    .alu_status_i     (alu_status_i),
    .mem_status_i     (mem_status),
    .ex_slots_i       (ex_slots),
    .ex_allowed_wb_i  (ex_allowed_wb),
    .alu_allowed_wb_i (alu_allowed_wb),
    .stall_o          (stall_o)
  );

endmodule : issue_ctrl_top

// ==== verilog/mem_unit_fsm.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module mem_unit_fsm
  import params_pkg::*;
  import pipe_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           issue_i,
  input  var dec_instr_t dec_instr_i,
  output mem_status_t    mem_status_o
);

  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  mem_state_e                 state_q;
  mem_state_e                 state_d;
  logic [CNT_W-1:0]           cnt_q;
  logic                       wr_en_q;
  logic [`REGISTER_WIDTH-1:0] rd_q;
  logic                       is_mem_op;
  logic                       accept;

  assign is_mem_op = issue_i &&
                     ((dec_instr_i.kind == kind_load) || (dec_instr_i.kind == kind_store));

  // A new access can start from idle or straight out of done
  assign accept = is_mem_op && (state_q != mem_busy);

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      mem_idle: if (accept) state_d = mem_busy;
      mem_busy: if (cnt_q == CNT_W'(1)) state_d = mem_done;
      mem_done: state_d = accept ? mem_busy : mem_idle;
      default:  state_d = mem_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= mem_idle;
      cnt_q   <= '0;
      wr_en_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        cnt_q   <= CNT_W'(`MEM_LATENCY);
        wr_en_q <= (dec_instr_i.kind == kind_load) && dec_instr_i.rd_wr_en;
      end else if (state_q == mem_busy) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_q <= dec_instr_i.rd;
    end
  end

  assign mem_status_o.valid     = (state_q != mem_idle);
  assign mem_status_o.busy      = (state_q == mem_busy);
  assign mem_status_o.reg_wr_en = wr_en_q;
  assign mem_status_o.wr_reg    = rd_q;

endmodule : mem_unit_fsm

// ==== verilog/mul_tracker.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module mul_tracker
  import params_pkg::*;
  import pipe_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       issue_i,
  input  var dec_instr_t             dec_instr_i,
  input  logic                       ex_allowed_wb_i,
  output ex_slot_t [`MUL_STAGES-1:0] ex_slots_o
);

  ex_slot_t [`MUL_STAGES-1:0] slots_q;
  ex_slot_t                   incoming;
  logic [`MUL_STAGES-1:0]     advance;
  logic                       accept;

  assign incoming.valid  = issue_i && (dec_instr_i.kind == kind_mul);
  assign incoming.wr_reg = dec_instr_i.rd;

  // advance[i]: slot i hands its entry on, ex5 only when granted
  always_comb begin : advance_chain
    advance[`MUL_STAGES-1] = ex_allowed_wb_i;
    for (int i = `MUL_STAGES - 2; i >= 0; i--) begin
      advance[i] = !slots_q[i+1].valid || advance[i+1];
    end
  end

  assign accept = !slots_q[0].valid || advance[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slots_q <= '0;
    end else begin
      if (accept) begin
        slots_q[0] <= incoming;
      end
      for (int i = 1; i < `MUL_STAGES; i++) begin
        if (advance[i-1]) begin
          slots_q[i] <= slots_q[i-1];
        end
      end
    end
  end

  assign ex_slots_o = slots_q;

endmodule : mul_tracker

// ==== verilog/rob_counter.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module rob_counter (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic issue_i,
  input  logic retire_i,
  output logic rob_full_o
);

  localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

  logic [CNT_W-1:0] count_q;

  // Issue and retire together leave the count as is
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else begin
      case ({issue_i, retire_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   if (count_q != '0) count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign rob_full_o = (count_q == CNT_W'(`ROB_DEPTH));

endmodule : rob_counter

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter
  import pipe_pkg::*;
(
  input  var mem_status_t mem_status_i,
  input  var ex_slot_t    ex5_slot_i,
  input  var alu_status_t alu_status_i,
  output logic            ex_allowed_wb_o,
  output logic            alu_allowed_wb_o,
  output wb_t             wb_o
);

  logic mem_req;
  logic ex_req;
  logic alu_req;

  // Memory requests only in done, with a load that writes
  assign mem_req = mem_status_i.valid && !mem_status_i.busy && mem_status_i.reg_wr_en;
  assign ex_req  = ex5_slot_i.valid;
  assign alu_req = alu_status_i.valid && alu_status_i.instr_finishes;

  // Fixed priority mem > mul > alu
  assign ex_allowed_wb_o  = ex_req && !mem_req;
  assign alu_allowed_wb_o = !mem_req && !ex_req;

  always_comb begin : wb_mux
    wb_o        = '0;
    wb_o.src    = wb_none;
    if (mem_req) begin
      wb_o.valid  = 1'b1;
      wb_o.src    = wb_mem;
      wb_o.wr_reg = mem_status_i.wr_reg;
    end else if (ex_req) begin
      wb_o.valid  = 1'b1;
      wb_o.src    = wb_mul;
      wb_o.wr_reg = ex5_slot_i.wr_reg;
    end else if (alu_req) begin
      wb_o.valid  = 1'b1;
      wb_o.src    = wb_alu;
      wb_o.wr_reg = alu_status_i.wr_reg;
    end
  end

endmodule : wb_arbiter
